// File: files.f
+incdir+bench
verilog/branchPkg.sv
verilog/instrDecode.sv
verilog/branchJudge.sv
verilog/redirectStage.sv
verilog/branchUnit.sv
bench/branchUnitTb.sv

// File: bench/branchModel.svh
`ifndef branchModelSvh
`define branchModelSvh

// instruction encoders for the stimulus
function automatic instrWordT encodeI(
    input logic [5:0]  op,
    input logic [4:0]  rs,
    input logic [4:0]  rt,
    input logic [15:0] imm
);
    instrWordT w;
    w.iFields.op    = op;
    w.iFields.rs    = rs;
    w.iFields.rt    = rt;
    w.iFields.imm16 = imm;
    return w;
endfunction

function automatic instrWordT encodeJ(input logic [5:0] op, input logic [25:0] index);
    instrWordT w;
    w.jFields.op      = op;
    w.jFields.index26 = index;
    return w;
endfunction

function automatic instrWordT encodeR(
    input logic [4:0] rs,
    input logic [4:0] rt,
    input logic [4:0] rd,
    input logic [5:0] funct
);
    instrWordT w;
    w.rFields.op    = opSpecial;
    w.rFields.rs    = rs;
    w.rFields.rt    = rt;
    w.rFields.rd    = rd;
    w.rFields.shamt = 5'd0;
    w.rFields.funct = funct;
    return w;
endfunction

// expected redirect straight from the MIPS branch rules
function automatic redirectT expectRedirect(input fetchReqT req);
    redirectT           res;
    logic [31:0]        word;
    logic [31:0]        pcNext;
    logic signed [31:0] a;
    logic signed [31:0] b;
    logic signed [15:0] imm;
    int                 offsetBytes;
    logic               condBranch;
    logic               cond;
    word        = req.instr;
    pcNext      = req.pc + 32'd4;
    a           = req.rsValue;
    b           = req.rtValue;
    imm         = word[15:0];
    offsetBytes = imm * 4;
    condBranch  = 1'b0;
    cond        = 1'b0;
    res.taken     = 1'b0;
    res.target    = pcNext;
    res.linkWrite = 1'b0;
    res.linkReg   = linkRegDefault;
    res.linkValue = req.pc + 32'd8;
    case (word[31:26])
        opBeq: begin
            condBranch = 1'b1;
            cond       = (a == b);
        end
        opBne: begin
            condBranch = 1'b1;
            cond       = (a != b);
        end
        opBgtz: begin
            condBranch = (word[20:16] == 5'd0);
            cond       = (a > 0);
        end
        opBlez: begin
            condBranch = (word[20:16] == 5'd0);
            cond       = (a <= 0);
        end
        opRegimm: begin
            condBranch    = (word[19:17] == 3'b000);
            // bit 16 picks >= 0 over < 0, bit 20 asks for a link
            cond          = word[16] ? (a >= 0) : (a < 0);
            res.linkWrite = condBranch && word[20];
        end
        opJ, opJal: begin
            res.taken     = 1'b1;
            res.target    = (pcNext & 32'hF000_0000) | ({6'd0, word[25:0]} << 2);
            res.linkWrite = (word[31:26] == opJal);
        end
        opSpecial: begin
            if (word[5:0] == functJr || word[5:0] == functJalr) begin
                res.taken  = 1'b1;
                res.target = req.rsValue;
            end
            if (word[5:0] == functJalr) begin
                res.linkWrite = 1'b1;
                res.linkReg   = word[15:11];
            end
        end
        default: condBranch = 1'b0;
    endcase
    if (condBranch && cond) begin
        res.taken  = 1'b1;
        res.target = pcNext + offsetBytes;
    end
    return res;
endfunction

`endif

// File: bench/branchUnitTb.sv
module branchUnitTb import branchPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    `include "branchModel.svh"

    localparam int itemCount     = 300;
    localparam int probeSpacing  = 25;
    localparam int timeoutCycles = 6000;

    logic     clk;
    logic     reset;
    logic     inReq;
    fetchReqT inBundle;
    logic     outAck;
    logic     inAck;
    logic     outReq;
    redirectT outBundle;

    redirectT expectedQ[$];
    redirectT expectedHead;
    int       expectedCount = 0;
    int       retired = 0;
    int       cycleCount = 0;
    logic     latencyProbe = 1'b0;

    branchUnit dut (
        .clk       (clk),
        .reset     (reset),
        .inReq     (inReq),
        .inBundle  (inBundle),
        .outAck    (outAck),
        .inAck     (inAck),
        .outReq    (outReq),
        .outBundle (outBundle)
    );

    task automatic abortRun(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic flagError(input string msg);
        abortRun($sformatf("FAIL at %0t ns: %s", $time, msg));
    endtask

    task automatic refreshHead();
        expectedCount = expectedQ.size();
        if (expectedCount > 0) begin
            expectedHead = expectedQ[0];
        end
    endtask

    // zero, negatives and small values show up often
    function automatic logic [31:0] pickValue();
        logic [31:0] v;
        case ($urandom_range(0, 6))
            0: v = 32'd0;
            1: v = $urandom | 32'h8000_0000;
            2: v = 32'($urandom_range(1, 3));
            3: v = 32'hFFFF_FFFF;
            4: v = 32'h8000_0000;
            5: v = 32'h7FFF_FFFF;
            default: v = $urandom;
        endcase
        return v;
    endfunction

    function automatic fetchReqT randomItem();
        fetchReqT   item;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [5:0] funct;
        logic [15:0] imm;
        rs    = 5'($urandom);
        rt    = 5'($urandom);
        rd    = 5'($urandom);
        imm   = 16'($urandom);
        funct = 6'($urandom);
        item.pc      = $urandom & 32'hFFFF_FFFC;
        item.rsValue = pickValue();
        item.rtValue = ($urandom_range(0, 3) == 0) ? item.rsValue : pickValue();
        case ($urandom_range(0, 15))
            0:  item.instr = encodeI(opBeq, rs, rt, imm);
            1:  item.instr = encodeI(opBne, rs, rt, imm);
            2:  item.instr = encodeI(opRegimm, rs, rtBgez, imm);
            3:  item.instr = encodeI(opRegimm, rs, rtBltz, imm);
            4:  item.instr = encodeI(opRegimm, rs, rtBgezal, imm);
            5:  item.instr = encodeI(opRegimm, rs, rtBltzal, imm);
            6:  item.instr = encodeI(opBgtz, rs, 5'd0, imm);
            7:  item.instr = encodeI(opBlez, rs, 5'd0, imm);
            8:  item.instr = encodeJ(opJ, 26'($urandom));
            9:  item.instr = encodeJ(opJal, 26'($urandom));
            10: item.instr = encodeR(rs, 5'd0, 5'd0, functJr);
            11: item.instr = encodeR(rs, 5'd0, rd, functJalr);
            12: begin
                // plain ALU R-type
                if (funct == functJr || funct == functJalr) begin
                    funct = 6'h20;
                end
                item.instr = encodeR(rs, rt, rd, funct);
            end
            13: item.instr = encodeI(rt[4] ? opBgtz : opBlez, rs, rt | 5'd1, imm);
            14: item.instr = encodeI(opRegimm, rs, rt | 5'b00010, imm);
            default: item.instr = encodeI(6'($urandom_range(8, 63)), rs, rt, imm);
        endcase
        return item;
    endfunction

    task automatic sendItem(input fetchReqT item);
        int hold;
        hold     = $urandom_range(0, 2);
        inBundle = item;
        inReq    = 1'b1;
        @(negedge clk);
        while (!inAck) @(negedge clk);
        expectedQ.push_back(expectRedirect(item));
        refreshHead();
        // request sometimes stays up past the ack
        repeat (hold) @(negedge clk);
        inReq = 1'b0;
        // stale data on the bus must not be taken again
        inBundle = randomItem();
        @(negedge clk);
        while (inAck) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            abortRun($sformatf("timeout: only %0d of %0d results came back in %0d cycles",
                retired, itemCount, cycleCount));
        end
    end

    // sink with random ack delay
    initial begin : sink
        int delay;
        outAck = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset && outReq && !outAck) begin
                delay = $urandom_range(0, 4);
                repeat (delay) @(negedge clk);
                outAck = 1'b1;
            end else if (outAck && !outReq) begin
                void'(expectedQ.pop_front());
                retired = retired + 1;
                refreshHead();
                // ack may linger after req has dropped
                delay = $urandom_range(0, 2);
                repeat (delay) @(negedge clk);
                outAck = 1'b0;
            end
        end
    end

    initial begin : source
        int i;
        void'($urandom(83733));
        reset    = 1'b1;
        inReq    = 1'b0;
        inBundle = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (i = 0; i < itemCount; i++) begin
            if (i % probeSpacing == 0) begin
                while (expectedQ.size() != 0 || outReq || outAck) @(negedge clk);
                latencyProbe = 1'b1;
            end
            sendItem(randomItem());
            if (latencyProbe) begin
                while (!outReq) @(negedge clk);
                @(negedge clk);
                latencyProbe = 1'b0;
            end else if ($urandom_range(0, 7) == 0) begin
                @(negedge clk);
            end
        end
        while (retired < itemCount) @(negedge clk);
        repeat (4) @(negedge clk);
        if (expectedQ.size() == 0 && retired == itemCount) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abortRun($sformatf("run ended with %0d results still expected", expectedQ.size()));
        end
    end

    resetClears: assert property (@(posedge clk) (!reset && $past(reset)) |-> (!inAck && !outReq))
        else flagError("inAck or outReq high right after reset");

    ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
        $rose(inAck) |-> $past(inReq))
        else flagError("inAck rose without inReq");
    ackHeld: assert property (@(posedge clk) disable iff (reset)
        (inAck && inReq) |=> inAck)
        else flagError("inAck dropped while inReq still high");
    ackDrops: assert property (@(posedge clk) disable iff (reset)
        (inAck && !inReq) |=> !inAck)
        else flagError("inAck stayed high after inReq fell");

    reqHeld: assert property (@(posedge clk) disable iff (reset)
        (outReq && !outAck) |=> outReq)
        else flagError("outReq dropped before outAck");
    reqDrops: assert property (@(posedge clk) disable iff (reset)
        (outReq && outAck) |=> !outReq)
        else flagError("outReq stayed high after outAck");
    reqWaitsAck: assert property (@(posedge clk) disable iff (reset)
        $rose(outReq) |-> !$past(outAck))
        else flagError("outReq rose while outAck was still high");
    bundleSteady: assert property (@(posedge clk) disable iff (reset)
        (outReq && $past(outReq)) |-> $stable(outBundle))
        else flagError("outBundle changed during the output handshake");

    resultExpected: assert property (@(posedge clk) disable iff (reset)
        (outReq && outAck) |-> (expectedCount > 0))
        else flagError("result delivered with no request pending");
    targetCorrect: assert property (@(posedge clk) disable iff (reset)
        (outReq && outAck) |->
            (outBundle.taken == expectedHead.taken && outBundle.target == expectedHead.target))
        else flagError($sformatf("taken/target %0b/%h, expected %0b/%h",
            $sampled(outBundle.taken), $sampled(outBundle.target),
            $sampled(expectedHead.taken), $sampled(expectedHead.target)));
    linkCorrect: assert property (@(posedge clk) disable iff (reset)
        (outReq && outAck) |->
            (outBundle.linkWrite == expectedHead.linkWrite
                && outBundle.linkReg == expectedHead.linkReg
                && outBundle.linkValue == expectedHead.linkValue))
        else flagError($sformatf("link %0b r%0d %h, expected %0b r%0d %h",
            $sampled(outBundle.linkWrite), $sampled(outBundle.linkReg),
            $sampled(outBundle.linkValue), $sampled(expectedHead.linkWrite),
            $sampled(expectedHead.linkReg), $sampled(expectedHead.linkValue)));

    // outReq three edges after the capture edge on an idle pipeline
    latencyExact: assert property (@(posedge clk) disable iff (reset)
        (latencyProbe && $rose(outReq)) |-> ($past(inAck, 3) && !$past(inAck, 4)))
        else flagError("outReq did not rise three edges after capture");

endmodule

// File: verilog/branchUnit.sv
module branchUnit import branchPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     inReq,
    input  fetchReqT inBundle,
    input  logic     outAck,
    output logic     inAck,
    output logic     outReq,
    output redirectT outBundle
);

    decodedT decoded;
    logic    decodeValid;
    logic    decodeReady;
    judgedT  judged;
    logic    judgeValid;
    logic    judgeReady;

    // classify
    instrDecode decodeStage (
        .clk         (clk),
        .reset       (reset),
        .inReq       (inReq),
        .inBundle    (inBundle),
        .decodeReady (decodeReady),
        .inAck       (inAck),
        .decoded     (decoded),
        .decodeValid (decodeValid)
    );

    // condition and link decision
    branchJudge judgeStage (
        .clk         (clk),
        .reset       (reset),
        .decoded     (decoded),
        .decodeValid (decodeValid),
        .judgeReady  (judgeReady),
        .decodeReady (decodeReady),
        .judged      (judged),
        .judgeValid  (judgeValid)
    );

    // target, link value, output handshake
    redirectStage outStage (
        .clk        (clk),
        .reset      (reset),
        .judged     (judged),
        .judgeValid (judgeValid),
        .outAck     (outAck),
        .judgeReady (judgeReady),
        .outReq     (outReq),
        .outBundle  (outBundle)
    );

endmodule

// File: verilog/redirectStage.sv
module redirectStage import branchPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  judgedT   judged,
    input  logic     judgeValid,
    input  logic     outAck,
    output logic     judgeReady,
    output logic     outReq,
    output redirectT outBundle
);

    logic [31:0] pcPlus4;
    logic [31:0] branchOffset;
    logic [31:0] target;
    logic        holdValid;
    logic        leaving;
    logic        capture;

    assign pcPlus4      = judged.pc + 32'd4;
    assign branchOffset = {{14{judged.offset[15]}}, judged.offset, 2'b00};

    // item leaves on the edge that sees req and ack both high
    assign leaving    = outReq && outAck;
    assign judgeReady = !holdValid || leaving;
    assign capture    = judgeValid && judgeReady;

    always_comb begin
        target = pcPlus4;
        if (judged.taken) begin
            case (judged.kind)
                kindBeq, kindBne, kindBgez, kindBltz,
                kindBgezal, kindBltzal, kindBgtz, kindBlez:
                    target = pcPlus4 + branchOffset;
                kindJ, kindJal:
                    target = {pcPlus4[31:28], judged.index, 2'b00};
                kindJr, kindJalr:
                    target = judged.rsValue;
                default:
                    target = pcPlus4;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            holdValid <= 1'b0;
            outReq    <= 1'b0;
        end else begin
            if (capture) begin
                holdValid <= 1'b1;
            end else if (leaving) begin
                holdValid <= 1'b0;
            end
            // raise only once the previous ack has been seen low
            if (leaving) begin
                outReq <= 1'b0;
            end else if (holdValid && !outReq && !outAck) begin
                outReq <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            outBundle.taken     <= judged.taken;
            outBundle.target    <= target;
            outBundle.linkWrite <= judged.linkWrite;
            outBundle.linkReg   <= judged.linkReg;
            outBundle.linkValue <= judged.pc + 32'd8;
        end
    end

    bundleHeld: assert property (@(posedge clk) disable iff (reset)
        (outReq && !outAck) |=> $stable(outBundle));

endmodule

// File: verilog/branchJudge.sv
module branchJudge import branchPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  decodedT decoded,
    input  logic    decodeValid,
    input  logic    judgeReady,
    output logic    decodeReady,
    output judgedT  judged,
    output logic    judgeValid
);

    logic signed [31:0] rsSigned;
    logic signed [31:0] rtSigned;
    logic               condHolds;
    logic               linkNext;
    logic               advance;

    assign rsSigned    = signed'(decoded.rsValue);
    assign rtSigned    = signed'(decoded.rtValue);
    assign decodeReady = !judgeValid || judgeReady;
    assign advance     = decodeValid && decodeReady;

    // signed compare per kind and jumps always go
    always_comb begin
        condHolds = 1'b0;
        linkNext  = 1'b0;
        case (decoded.kind)
            kindBeq:  condHolds = (rsSigned == rtSigned);
            kindBne:  condHolds = (rsSigned != rtSigned);
            kindBgez: condHolds = (rsSigned >= 0);
            kindBltz: condHolds = (rsSigned < 0);
            kindBgezal: begin
                // link happens even when the branch falls through
                condHolds = (rsSigned >= 0);
                linkNext  = 1'b1;
            end
            kindBltzal: begin
                condHolds = (rsSigned < 0);
                linkNext  = 1'b1;
            end
            kindBgtz: condHolds = (rsSigned > 0);
            kindBlez: condHolds = (rsSigned <= 0);
            kindJ:    condHolds = 1'b1;
            kindJal: begin
                condHolds = 1'b1;
                linkNext  = 1'b1;
            end
            kindJr:   condHolds = 1'b1;
            kindJalr: begin
                condHolds = 1'b1;
                linkNext  = 1'b1;
            end
            default: begin
                condHolds = 1'b0;
                linkNext  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            judgeValid <= 1'b0;
        end else if (advance) begin
            judgeValid <= 1'b1;
        end else if (judgeReady) begin
            judgeValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            judged.pc        <= decoded.pc;
            judged.kind      <= decoded.kind;
            judged.rsValue   <= decoded.rsValue;
            judged.offset    <= decoded.offset;
            judged.index     <= decoded.index;
            judged.linkReg   <= decoded.linkReg;
            judged.taken     <= condHolds;
            judged.linkWrite <= linkNext;
        end
    end

    noneIsInert: assert property (@(posedge clk) disable iff (reset)
        (judgeValid && judged.kind == kindNone) |-> (!judged.taken && !judged.linkWrite));

endmodule

// File: verilog/instrDecode.sv
module instrDecode import branchPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     inReq,
    input  fetchReqT inBundle,
    input  logic     decodeReady,
    output logic     inAck,
    output decodedT  decoded,
    output logic     decodeValid
);

    instrWordT  word;
    branchKindT kind;
    logic [4:0] linkReg;
    logic       stageReady;
    logic       capture;

    assign word       = inBundle.instr;
    assign stageReady = !decodeValid || decodeReady;
    // a fresh request is one seen while inAck is still low
    assign capture    = inReq && !inAck && stageReady;

    always_comb begin
        kind    = kindNone;
        linkReg = linkRegDefault;
        case (word.iFields.op)
            opBeq:    kind = kindBeq;
            opBne:    kind = kindBne;
            opRegimm: begin
                case (word.iFields.rt)
                    rtBgez:   kind = kindBgez;
                    rtBltz:   kind = kindBltz;
                    rtBgezal: kind = kindBgezal;
                    rtBltzal: kind = kindBltzal;
                    default:  kind = kindNone;
                endcase
            end
            opBgtz:   if (word.iFields.rt == 5'd0) kind = kindBgtz;
            opBlez:   if (word.iFields.rt == 5'd0) kind = kindBlez;
            opJ:      kind = kindJ;
            opJal:    kind = kindJal;
            opSpecial: begin
                // only jr and jalr count; other R-type is plain ALU work
                case (word.rFields.funct)
                    functJr: kind = kindJr;
                    functJalr: begin
                        kind    = kindJalr;
                        linkReg = word.rFields.rd;
                    end
                    default: kind = kindNone;
                endcase
            end
            default:  kind = kindNone;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inAck       <= 1'b0;
            decodeValid <= 1'b0;
        end else begin
            if (capture) begin
                inAck <= 1'b1;
            end else if (!inReq) begin
                inAck <= 1'b0;
            end
            if (capture) begin
                decodeValid <= 1'b1;
            end else if (decodeReady) begin
                decodeValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            decoded.pc      <= inBundle.pc;
            decoded.kind    <= kind;
            decoded.rsValue <= inBundle.rsValue;
            decoded.rtValue <= inBundle.rtValue;
            decoded.offset  <= word.iFields.imm16;
            decoded.index   <= word.jFields.index26;
            decoded.linkReg <= linkReg;
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
        $rose(inAck) |-> $past(inReq));

endmodule

// File: verilog/branchPkg.sv
package branchPkg;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opRegimm  = 6'b000001;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opBlez    = 6'b000110;
    localparam logic [5:0] opBgtz    = 6'b000111;

    // REGIMM rt sub-codes
    localparam logic [4:0] rtBltz   = 5'b00000;
    localparam logic [4:0] rtBgez   = 5'b00001;
    localparam logic [4:0] rtBltzal = 5'b10000;
    localparam logic [4:0] rtBgezal = 5'b10001;

    // SPECIAL funct codes
    localparam logic [5:0] functJr   = 6'b001000;
    localparam logic [5:0] functJalr = 6'b001001;

    localparam logic [4:0] linkRegDefault = 5'd31;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFieldsT;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index26;
    } jFieldsT;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    // one instruction word, three ways of reading it
    typedef union packed {
        iFieldsT iFields;
        jFieldsT jFields;
        rFieldsT rFields;
    } instrWordT;

    typedef enum logic [3:0] {
        kindNone,
        kindBeq,
        kindBne,
        kindBgez,
        kindBltz,
        kindBgezal,
        kindBltzal,
        kindBgtz,
        kindBlez,
        kindJ,
        kindJal,
        kindJr,
        kindJalr
    } branchKindT;

    typedef struct packed {
        logic [31:0] pc;
        instrWordT   instr;
        logic [31:0] rsValue;
        logic [31:0] rtValue;
    } fetchReqT;

    typedef struct packed {
        logic [31:0] pc;
        branchKindT  kind;
        logic [31:0] rsValue;
        logic [31:0] rtValue;
        logic [15:0] offset;
        logic [25:0] index;
        logic [4:0]  linkReg;
    } decodedT;

    typedef struct packed {
        logic [31:0] pc;
        branchKindT  kind;
        logic [31:0] rsValue;
        logic [15:0] offset;
        logic [25:0] index;
        logic [4:0]  linkReg;
        logic        taken;
        logic        linkWrite;
    } judgedT;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
        logic        linkWrite;
        logic [4:0]  linkReg;
        logic [31:0] linkValue;
    } redirectT;

endpackage
